// File: design/aa_types_pkg.sv
package aa_types_pkg;

  // --------------------
  // protocol widths
  // --------------------

  // AXI-Lite address, also the address beat of a command
  typedef logic [31:0] addr_t;

  // data word on both the stream and the AXI-Lite side
  typedef logic [31:0] data_t;

  // byte enables of one data word
  typedef logic [3:0] strb_t;

  // --------------------
  // stream user codes
  // --------------------

  // beat type carried in tuser
  typedef enum logic [1:0] {
    tu_axis      = 2'b00,  // plain stream, dropped here
    tu_write     = 2'b01,  // two beats, address then data
    tu_read_addr = 2'b10,  // one address beat
    tu_read_resp = 2'b11   // read data going back
  } tuser_e;

  // decoded command kind handed to the executor
  typedef enum logic {
    cmd_read  = 1'b0,
    cmd_write = 1'b1
  } cmd_kind_e;

endpackage

// File: design/aa_map_pkg.sv
package aa_map_pkg;

  // --------------------
  // address regions
  // --------------------

  // address bits 15..12 pick the region
  typedef logic [3:0] region_t;

  // offset inside a region, address bits 11..0
  typedef logic [11:0] ofs_t;

  // bridge registers
  localparam region_t REGION_AA_REG = 4'h2;
  // mailbox words
  localparam region_t REGION_MBOX   = 4'h3;

  // bridge register offsets
  localparam ofs_t OFS_INTR_ENABLE = 12'h000;
  localparam ofs_t OFS_INTR_STATUS = 12'h004;

  // default mailbox size in words
  localparam int MBOX_WORDS_DEF = 2;

endpackage

// File: design/aa_cmd_if.sv
`timescale 1ns/1ps

// decoded command from the stream receiver to the executor
interface aa_cmd_if;

  // rx side holds valid and payload until ready
  logic                      valid;
  logic                      ready;
  aa_types_pkg::cmd_kind_e   kind;
  aa_types_pkg::addr_t       addr;
  // only meaningful for writes
  aa_types_pkg::data_t       data;

  modport rx (
    output valid, kind, addr, data,
    input  ready
  );

  modport exec (
    input  valid, kind, addr, data,
    output ready
  );

endinterface

// File: design/aa_reg_if.sv
`timescale 1ns/1ps

// single-cycle register access from the executor to the local registers
interface aa_reg_if;

  logic                 en;
  logic                 wr;
  // region already decoded by the executor
  logic                 is_mbox;
  aa_map_pkg::ofs_t     ofs;
  aa_types_pkg::data_t  wdata;
  // combinational read data
  aa_types_pkg::data_t  rdata;

  modport exec (output en, wr, is_mbox, ofs, wdata, input rdata);

  modport regs (input en, wr, is_mbox, ofs, wdata, output rdata);

endinterface

// File: design/aa_cmd_rx.sv
`timescale 1ns/1ps

module aa_cmd_rx (
  input  logic                 axis_clk,
  input  logic                 axis_rst_n,
  input  logic                 tvalid,
  input  aa_types_pkg::data_t  tdata,
  input  aa_types_pkg::tuser_e tuser,
  output logic                 tready,
  aa_cmd_if.rx                 cmd
);

  // command register full flag
  logic cmd_valid_q;
  // set after the address beat of a write
  logic wr_phase;
  logic beat;

  // accept beats as long as the command register is free
  // a half collected write leaves it free so its data beat still goes in
  assign tready = !cmd_valid_q;
  assign beat   = tvalid && tready;

  assign cmd.valid = cmd_valid_q;

  // --------------------
  // control
  // --------------------
  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      cmd_valid_q <= 1'b0;
      wr_phase    <= 1'b0;
    end else begin
      // executor took the command
      if (cmd_valid_q && cmd.ready) begin
        cmd_valid_q <= 1'b0;
      end
      if (beat) begin
        case (tuser)
          aa_types_pkg::tu_write: begin
            // second beat completes the write
            wr_phase <= !wr_phase;
            if (wr_phase) begin
              cmd_valid_q <= 1'b1;
            end
          end
          aa_types_pkg::tu_read_addr: begin
            // a read in the middle of a write drops the half write
            wr_phase    <= 1'b0;
            cmd_valid_q <= 1'b1;
          end
          // axis and read_resp beats are swallowed
          default: ;
        endcase
      end
    end
  end

  // --------------------
  // payload
  // --------------------
  always_ff @(posedge axis_clk) begin
    if (beat) begin
      if (tuser == aa_types_pkg::tu_write) begin
        if (!wr_phase) begin
          cmd.addr <= tdata;
          cmd.kind <= aa_types_pkg::cmd_write;
        end else begin
          cmd.data <= tdata;
        end
      end else if (tuser == aa_types_pkg::tu_read_addr) begin
        cmd.addr <= tdata;
        cmd.kind <= aa_types_pkg::cmd_read;
      end
    end
  end

endmodule

// File: design/aa_exec.sv
`timescale 1ns/1ps

module aa_exec (
  input  logic                axis_clk,
  input  logic                axis_rst_n,
  aa_cmd_if.exec              cmd,
  aa_reg_if.exec              regs,
  output logic                m_awvalid,
  output logic                m_arvalid,
  output logic                m_wvalid,
  output logic                m_rready,
  output aa_types_pkg::addr_t m_awaddr,
  output aa_types_pkg::addr_t m_araddr,
  output aa_types_pkg::data_t m_wdata,
  output aa_types_pkg::strb_t m_wstrb,
  input  logic                m_awready,
  input  logic                m_wready,
  input  logic                m_arready,
  input  logic                m_rvalid,
  input  aa_types_pkg::data_t m_rdata,
  output logic                resp_valid,
  output aa_types_pkg::data_t resp_data,
  input  logic                resp_ready
);

  typedef enum logic [2:0] {
    st_idle,
    st_local,
    st_wr_bus,
    st_rd_addr,
    st_rd_data
  } state_e;

  state_e                  state;
  aa_types_pkg::addr_t     addr_q;
  aa_types_pkg::data_t     data_q;
  aa_types_pkg::cmd_kind_e kind_q;
  aa_map_pkg::region_t     cmd_region;
  logic                    cmd_local;
  logic                    take;
  logic                    aw_done;
  logic                    w_done;
  logic                    aw_fire;
  logic                    w_fire;

  // one command at a time, idle means ready
  assign cmd.ready  = (state == st_idle);
  assign take       = cmd.valid && cmd.ready;
  assign cmd_region = cmd.addr[15:12];
  // regions 2 and 3 never reach the bus
  assign cmd_local  = (cmd_region == aa_map_pkg::REGION_AA_REG) ||
                      (cmd_region == aa_map_pkg::REGION_MBOX);

  // --------------------
  // AXI-Lite outputs
  // --------------------
  // top nibble is the strobe, not part of the bus address
  assign m_awaddr  = {4'b0000, addr_q[27:0]};
  assign m_araddr  = {4'b0000, addr_q[27:0]};
  assign m_wstrb   = addr_q[31:28];
  assign m_wdata   = data_q;
  assign m_awvalid = (state == st_wr_bus) && !aw_done;
  assign m_wvalid  = (state == st_wr_bus) && !w_done;
  assign m_arvalid = (state == st_rd_addr);
  // R only taken when the response can move on in the same cycle
  assign m_rready  = (state == st_rd_data) && resp_ready;
  assign aw_fire   = m_awvalid && m_awready;
  assign w_fire    = m_wvalid && m_wready;

  // local register access lasts while in st_local
  assign regs.en      = (state == st_local);
  assign regs.wr      = (kind_q == aa_types_pkg::cmd_write);
  assign regs.is_mbox = (aa_map_pkg::region_t'(addr_q[15:12]) == aa_map_pkg::REGION_MBOX);
  assign regs.ofs     = addr_q[11:0];
  assign regs.wdata   = data_q;

  // response from a local read or straight from the R channel
  assign resp_valid = ((state == st_local) && (kind_q == aa_types_pkg::cmd_read)) ||
                      ((state == st_rd_data) && m_rvalid);
  assign resp_data  = (state == st_rd_data) ? m_rdata : regs.rdata;

  // --------------------
  // FSM
  // --------------------
  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      state   <= st_idle;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (take) begin
            if (cmd_local) begin
              state <= st_local;
            end else if (cmd.kind == aa_types_pkg::cmd_write) begin
              state <= st_wr_bus;
            end else begin
              state <= st_rd_addr;
            end
          end
        end
        st_local: begin
          // a write finishes at once, a read waits for the response slot
          if (kind_q == aa_types_pkg::cmd_write || resp_ready) begin
            state <= st_idle;
          end
        end
        st_wr_bus: begin
          if (aw_fire) begin
            aw_done <= 1'b1;
          end
          if (w_fire) begin
            w_done <= 1'b1;
          end
          // both channels done, in any order
          if ((aw_done || aw_fire) && (w_done || w_fire)) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            state   <= st_idle;
          end
        end
        st_rd_addr: begin
          if (m_arready) begin
            state <= st_rd_data;
          end
        end
        st_rd_data: begin
          if (m_rvalid && m_rready) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // command payload, loaded when taken
  always_ff @(posedge axis_clk) begin
    if (take) begin
      addr_q <= cmd.addr;
      data_q <= cmd.data;
      kind_q <= cmd.kind;
    end
  end

endmodule

// File: design/aa_local_regs.sv
`timescale 1ns/1ps

module aa_local_regs #(
  parameter int mbox_words = aa_map_pkg::MBOX_WORDS_DEF
) (
  input  logic    axis_clk,
  input  logic    axis_rst_n,
  aa_reg_if.regs  regs,
  output logic    mb_irq
);

  localparam int idx_w = (mbox_words > 1) ? $clog2(mbox_words) : 1;

  aa_types_pkg::data_t mbox [mbox_words];
  logic [idx_w-1:0]    mb_idx;
  logic                intr_enable;
  logic                intr_status;
  logic                mbox_wr;
  logic                reg_wr;

  // word select sits above the byte offset
  assign mb_idx  = (mbox_words == 1) ? '0 : regs.ofs[2 +: idx_w];
  assign mbox_wr = regs.en && regs.wr && regs.is_mbox;
  assign reg_wr  = regs.en && regs.wr && !regs.is_mbox;

  // --------------------
  // mailbox
  // --------------------
  always_ff @(posedge axis_clk) begin
    if (mbox_wr) begin
      mbox[mb_idx] <= regs.wdata;
    end
  end

  // --------------------
  // interrupt
  // --------------------
  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      intr_enable <= 1'b0;
      intr_status <= 1'b0;
      mb_irq      <= 1'b0;
    end else begin
      if (reg_wr && regs.ofs == aa_map_pkg::OFS_INTR_ENABLE) begin
        intr_enable <= regs.wdata[0];
      end
      // mailbox write from the stream raises status, write 1 clears it
      if (mbox_wr) begin
        intr_status <= 1'b1;
      end else if (reg_wr && regs.ofs == aa_map_pkg::OFS_INTR_STATUS && regs.wdata[0]) begin
        intr_status <= 1'b0;
      end
      mb_irq <= intr_status && intr_enable;
    end
  end

  // read mux, unmapped offsets read zero
  always_comb begin
    regs.rdata = '0;
    if (regs.is_mbox) begin
      regs.rdata = mbox[mb_idx];
    end else if (regs.ofs == aa_map_pkg::OFS_INTR_ENABLE) begin
      regs.rdata = aa_types_pkg::data_t'(intr_enable);
    end else if (regs.ofs == aa_map_pkg::OFS_INTR_STATUS) begin
      regs.rdata = aa_types_pkg::data_t'(intr_status);
    end
  end

endmodule

// File: design/aa_resp_tx.sv
`timescale 1ns/1ps

module aa_resp_tx (
  input  logic                 axis_clk,
  input  logic                 axis_rst_n,
  input  logic                 resp_valid,
  input  aa_types_pkg::data_t  resp_data,
  output logic                 resp_ready,
  output logic                 tvalid,
  output aa_types_pkg::data_t  tdata,
  output aa_types_pkg::tuser_e tuser,
  input  logic                 tready
);

  logic                tvalid_q;
  aa_types_pkg::data_t tdata_q;

  // one-entry buffer, refuse new data while a beat is out
  assign resp_ready = !tvalid_q;

  assign tvalid = tvalid_q;
  assign tdata  = tdata_q;
  // everything sent back is a read response
  assign tuser  = aa_types_pkg::tu_read_resp;

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      tvalid_q <= 1'b0;
    end else if (resp_valid && resp_ready) begin
      tvalid_q <= 1'b1;
    end else if (tready) begin
      tvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge axis_clk) begin
    if (resp_valid && resp_ready) begin
      tdata_q <= resp_data;
    end
  end

endmodule

// File: design/aa_bridge_top.sv
`timescale 1ns/1ps

module aa_bridge_top #(
  parameter int mbox_words = aa_map_pkg::MBOX_WORDS_DEF
) (
  input  logic                axis_clk,
  input  logic                axis_rst_n,
  // stream slave, commands in
  input  logic                as_aa_tvalid,
  input  aa_types_pkg::data_t as_aa_tdata,
  input  logic [1:0]          as_aa_tuser,
  output logic                aa_as_tready,
  // stream master, read responses out
  output logic                aa_as_tvalid,
  output aa_types_pkg::data_t aa_as_tdata,
  output logic [1:0]          aa_as_tuser,
  input  logic                as_aa_tready,
  // AXI-Lite master
  output logic                m_awvalid,
  output aa_types_pkg::addr_t m_awaddr,
  input  logic                m_awready,
  output logic                m_wvalid,
  output aa_types_pkg::data_t m_wdata,
  output aa_types_pkg::strb_t m_wstrb,
  input  logic                m_wready,
  output logic                m_arvalid,
  output aa_types_pkg::addr_t m_araddr,
  input  logic                m_arready,
  input  logic                m_rvalid,
  input  aa_types_pkg::data_t m_rdata,
  output logic                m_rready,
  // mailbox interrupt
  output logic                mb_irq
);

  logic                resp_valid;
  logic                resp_ready;
  aa_types_pkg::data_t resp_data;

  aa_cmd_if cmd_bus ();
  aa_reg_if reg_bus ();

  // --------------------
  // pipeline stages
  // --------------------
  aa_cmd_rx cmd_rx_inst (
    .axis_clk   (axis_clk),
    .axis_rst_n (axis_rst_n),
    .tvalid     (as_aa_tvalid),
    .tdata      (as_aa_tdata),
    .tuser      (aa_types_pkg::tuser_e'(as_aa_tuser)),
    .tready     (aa_as_tready),
    .cmd        (cmd_bus.rx)
  );

  aa_exec exec_inst (
    .axis_clk   (axis_clk),
    .axis_rst_n (axis_rst_n),
    .cmd        (cmd_bus.exec),
    .regs       (reg_bus.exec),
    .m_awvalid  (m_awvalid),
    .m_arvalid  (m_arvalid),
    .m_wvalid   (m_wvalid),
    .m_rready   (m_rready),
    .m_awaddr   (m_awaddr),
    .m_araddr   (m_araddr),
    .m_wdata    (m_wdata),
    .m_wstrb    (m_wstrb),
    .m_awready  (m_awready),
    .m_wready   (m_wready),
    .m_arready  (m_arready),
    .m_rvalid   (m_rvalid),
    .m_rdata    (m_rdata),
    .resp_valid (resp_valid),
    .resp_data  (resp_data),
    .resp_ready (resp_ready)
  );

  // mailbox and interrupt registers
  aa_local_regs #(
    .mbox_words (mbox_words)
  ) local_regs_inst (
    .axis_clk   (axis_clk),
    .axis_rst_n (axis_rst_n),
    .regs       (reg_bus.regs),
    .mb_irq     (mb_irq)
  );

  aa_resp_tx resp_tx_inst (
    .axis_clk   (axis_clk),
    .axis_rst_n (axis_rst_n),
    .resp_valid (resp_valid),
    .resp_data  (resp_data),
    .resp_ready (resp_ready),
    .tvalid     (aa_as_tvalid),
    .tdata      (aa_as_tdata),
    .tuser      (aa_as_tuser),
    .tready     (as_aa_tready)
  );

endmodule

// File: test/tb_aa_bridge.sv
`timescale 1ns/1ps

module tb_aa_bridge;

  // stream user codes
  localparam logic [1:0] c_axis = 2'b00;
  localparam logic [1:0] c_wr   = 2'b01;
  localparam logic [1:0] c_rd   = 2'b10;
  localparam logic [1:0] c_resp = 2'b11;
  // bus memory preload is address ^ fill_const
  localparam logic [31:0] fill_const = 32'h5A00_0000;
  localparam int timeout_cycles = 300;
  localparam int n_entries = 28;

  // one command per entry
  // exp and irq apply to reads only
  typedef struct packed {
    logic [1:0]  code;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp;
    logic        chk_irq;
    logic        irq;
  } entry_t;

  localparam entry_t cmd_table [n_entries] = '{
    // external writes and reads with the strobe in address bits 31..28
    '{c_wr,   32'hF000_0100, 32'h1234_5678, 32'h0000_0000, 1'b0, 1'b0},
    '{c_rd,   32'h0000_0100, 32'h0000_0000, 32'h1234_5678, 1'b1, 1'b0},
    '{c_wr,   32'h3000_0200, 32'hAABB_CCDD, 32'h0000_0000, 1'b0, 1'b0},
    '{c_rd,   32'h8000_0200, 32'h0000_0000, 32'h5A00_CCDD, 1'b0, 1'b0},
    '{c_rd,   32'h0000_0440, 32'h0000_0000, 32'h5A00_0440, 1'b0, 1'b0},
    // beats that must be dropped
    '{c_axis, 32'h0000_0000, 32'hDEAD_BEEF, 32'h0000_0000, 1'b0, 1'b0},
    '{c_resp, 32'h0000_0000, 32'hFEED_F00D, 32'h0000_0000, 1'b0, 1'b0},
    '{c_rd,   32'h0001_0800, 32'h0000_0000, 32'h5A01_0800, 1'b0, 1'b0},
    // mailbox with interrupt disabled
    '{c_wr,   32'h0000_3000, 32'hCAFE_0001, 32'h0000_0000, 1'b0, 1'b0},
    '{c_wr,   32'h0000_3004, 32'hCAFE_0002, 32'h0000_0000, 1'b0, 1'b0},
    '{c_rd,   32'h0000_3000, 32'h0000_0000, 32'hCAFE_0001, 1'b0, 1'b0},
    '{c_rd,   32'h0000_3004, 32'h0000_0000, 32'hCAFE_0002, 1'b1, 1'b0},
    '{c_rd,   32'h0000_2004, 32'h0000_0000, 32'h0000_0001, 1'b1, 1'b0},
    '{c_wr,   32'h0000_2004, 32'h0000_0001, 32'h0000_0000, 1'b0, 1'b0},
    '{c_rd,   32'h0000_2004, 32'h0000_0000, 32'h0000_0000, 1'b1, 1'b0},
    // enable set so a mailbox write raises the irq
    '{c_wr,   32'h0000_2000, 32'h0000_0001, 32'h0000_0000, 1'b0, 1'b0},
    '{c_rd,   32'h0000_2000, 32'h0000_0000, 32'h0000_0001, 1'b1, 1'b0},
    '{c_wr,   32'h0000_3000, 32'h1111_2222, 32'h0000_0000, 1'b0, 1'b0},
    '{c_rd,   32'h0000_2004, 32'h0000_0000, 32'h0000_0001, 1'b1, 1'b1},
    '{c_wr,   32'h0000_2004, 32'h0000_0001, 32'h0000_0000, 1'b0, 1'b0},
    '{c_rd,   32'h0000_2004, 32'h0000_0000, 32'h0000_0000, 1'b1, 1'b0},
    '{c_rd,   32'h0000_3000, 32'h0000_0000, 32'h1111_2222, 1'b0, 1'b0},
    // partial strobe 0101
    '{c_wr,   32'h5000_0040, 32'h0BAD_F00D, 32'h0000_0000, 1'b0, 1'b0},
    '{c_rd,   32'h0000_0040, 32'h0000_0000, 32'h5AAD_000D, 1'b0, 1'b0},
    // disabled again so status sets but irq stays low
    '{c_wr,   32'h0000_2000, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0},
    '{c_wr,   32'h0000_3004, 32'h3333_4444, 32'h0000_0000, 1'b0, 1'b0},
    '{c_rd,   32'h0000_2004, 32'h0000_0000, 32'h0000_0001, 1'b1, 1'b0},
    '{c_rd,   32'h0000_3004, 32'h0000_0000, 32'h3333_4444, 1'b0, 1'b0}
  };

  logic        axis_clk;
  logic        axis_rst_n;
  logic        as_aa_tvalid;
  logic [31:0] as_aa_tdata;
  logic [1:0]  as_aa_tuser;
  logic        aa_as_tready;
  logic        aa_as_tvalid;
  logic [31:0] aa_as_tdata;
  logic [1:0]  aa_as_tuser;
  logic        as_aa_tready;
  logic        m_awvalid;
  logic [31:0] m_awaddr;
  logic        m_awready;
  logic        m_wvalid;
  logic [31:0] m_wdata;
  logic [3:0]  m_wstrb;
  logic        m_wready;
  logic        m_arvalid;
  logic [31:0] m_araddr;
  logic        m_arready;
  logic        m_rvalid;
  logic [31:0] m_rdata;
  logic        m_rready;
  logic        mb_irq;

  // expected traffic in command order
  logic [31:0] exp_rsp [$];
  logic [67:0] exp_wr [$];
  logic [31:0] exp_ar [$];
  // bus model state
  logic [31:0] mem [logic [31:0]];
  logic [31:0] aw_log [$];
  logic [35:0] w_log [$];
  logic [31:0] rd_pend [$];
  logic        r_fire;
  // stream master state
  logic        held;
  logic [31:0] held_data;
  int          stall;
  int          error_count;
  int          responses;
  int          bus_writes;
  int          bus_reads;
  entry_t      ent;
  logic        is_local;
  // set once any wait runs out of time
  logic        timed_out;

  aa_bridge_top aa_bridge_top_inst (.*);

  initial begin
    axis_clk = 1'b0;
    forever #10 axis_clk = ~axis_clk;
  end

  // --------------------
  // helpers
  // --------------------
  task automatic finish_run();
    $display("errors: %0d, responses: %0d, axi-lite writes: %0d, axi-lite reads: %0d",
             error_count, responses, bus_writes, bus_reads);
    if (error_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    $display("timeout after %0d cycles waiting for %s", timeout_cycles, what);
    error_count++;
    timed_out = 1'b1;
  endtask

  function automatic logic [31:0] mem_read(input logic [31:0] addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    return addr ^ fill_const;
  endfunction

  // drives one beat on the stream slave port from a falling edge
  task automatic send_beat(input logic [1:0] code, input logic [31:0] data);
    int waited;
    waited = 0;
    as_aa_tvalid = 1'b1;
    as_aa_tdata  = data;
    as_aa_tuser  = code;
    while (!aa_as_tready && !timed_out) begin
      @(negedge axis_clk);
      waited++;
      if (waited > timeout_cycles) begin
        report_timeout("aa_as_tready");
      end
    end
    @(negedge axis_clk);
    as_aa_tvalid = 1'b0;
  endtask

  // all expected responses and bus transfers seen
  task automatic wait_drained(input string what);
    int waited;
    waited = 0;
    while ((exp_rsp.size() != 0 || exp_wr.size() != 0 || exp_ar.size() != 0) &&
           !timed_out) begin
      @(negedge axis_clk);
      waited++;
      if (waited > timeout_cycles) begin
        report_timeout(what);
      end
    end
  endtask

  // AW and W both seen so memory updates under the strobe
  task automatic bus_write(input logic [31:0] addr, input logic [35:0] sw);
    logic [67:0] e;
    logic [31:0] word;
    bus_writes++;
    $display("%0d ns axi-lite write addr %h strb %h data %h", $time, addr, sw[35:32],
             sw[31:0]);
    if (exp_wr.size() == 0) begin
      error_count++;
      $display("Error at %0d ns: unexpected AXI-Lite write to %h", $time, addr);
    end else begin
      e = exp_wr.pop_front();
      if (e !== {addr, sw}) begin
        error_count++;
        $display("Error at %0d ns: write addr/strb/data %h %h %h expected %h %h %h", $time,
                 addr, sw[35:32], sw[31:0], e[67:36], e[35:32], e[31:0]);
      end
    end
    word = mem_read(addr);
    for (int b = 0; b < 4; b++) begin
      if (sw[32+b]) begin
        word[8*b +: 8] = sw[8*b +: 8];
      end
    end
    mem[addr] = word;
  endtask

  // --------------------
  // AXI-Lite slave model
  // --------------------
  initial begin
    forever begin
      @(negedge axis_clk);
      if (axis_rst_n) begin
        m_awready = ($urandom % 3) == 0;
        m_wready  = ($urandom % 3) == 0;
        if (m_awvalid && m_awready) begin
          aw_log.push_back(m_awaddr);
        end
        if (m_wvalid && m_wready) begin
          w_log.push_back({m_wstrb, m_wdata});
        end
        if (aw_log.size() != 0 && w_log.size() != 0) begin
          bus_write(aw_log.pop_front(), w_log.pop_front());
        end
      end
    end
  end

  initial begin
    forever begin
      @(negedge axis_clk);
      if (axis_rst_n) begin
        // R handled before AR so data never leads its address
        if (r_fire) begin
          m_rvalid = 1'b0;
        end
        if (!m_rvalid && rd_pend.size() != 0 && ($urandom % 2) == 0) begin
          m_rvalid = 1'b1;
          m_rdata  = mem_read(rd_pend.pop_front());
        end
        r_fire    = m_rvalid && m_rready;
        m_arready = ($urandom % 3) == 0;
        if (m_arvalid && m_arready) begin
          bus_reads++;
          if (exp_ar.size() == 0) begin
            error_count++;
            $display("Error at %0d ns: unexpected AXI-Lite read of %h", $time, m_araddr);
          end else if (m_araddr !== exp_ar[0]) begin
            error_count++;
            $display("Error at %0d ns: araddr %h expected %h", $time, m_araddr, exp_ar[0]);
          end
          if (exp_ar.size() != 0) begin
            void'(exp_ar.pop_front());
          end
          rd_pend.push_back(m_araddr);
        end
      end
    end
  end

  // --------------------
  // stream master side
  // --------------------
  initial begin
    forever begin
      @(negedge axis_clk);
      if (axis_rst_n) begin
        // a stalled beat must not change
        if (held && (!aa_as_tvalid || aa_as_tdata !== held_data)) begin
          error_count++;
          $display("Error at %0d ns: response beat changed while stalled", $time);
        end
        if (stall > 0) begin
          stall--;
          as_aa_tready = 1'b0;
        end else if (($urandom % 16) == 0) begin
          stall = 3 + $urandom % 6;
          as_aa_tready = 1'b0;
        end else begin
          as_aa_tready = ($urandom % 4) != 0;
        end
        held      = aa_as_tvalid && !as_aa_tready;
        held_data = aa_as_tdata;
        if (aa_as_tvalid && as_aa_tready) begin
          responses++;
          if (aa_as_tuser !== c_resp) begin
            error_count++;
            $display("Error at %0d ns: response tuser %b expected %b", $time,
                     aa_as_tuser, c_resp);
          end
          if (exp_rsp.size() == 0) begin
            error_count++;
            $display("Error at %0d ns: unexpected response %h", $time, aa_as_tdata);
          end else if (aa_as_tdata !== exp_rsp[0]) begin
            error_count++;
            $display("Error at %0d ns: response %h expected %h", $time, aa_as_tdata,
                     exp_rsp[0]);
          end
          if (exp_rsp.size() != 0) begin
            void'(exp_rsp.pop_front());
          end
        end
      end
    end
  end

  // --------------------
  // main sequence
  // --------------------
  initial begin
    void'($urandom(57559));
    axis_rst_n   = 1'b0;
    as_aa_tvalid = 1'b0;
    as_aa_tdata  = '0;
    as_aa_tuser  = c_axis;
    as_aa_tready = 1'b0;
    m_awready    = 1'b0;
    m_wready     = 1'b0;
    m_arready    = 1'b0;
    m_rvalid     = 1'b0;
    m_rdata      = '0;
    r_fire       = 1'b0;
    held         = 1'b0;
    held_data    = '0;
    stall        = 0;
    error_count  = 0;
    responses    = 0;
    bus_writes   = 0;
    bus_reads    = 0;
    timed_out    = 1'b0;
    repeat (16) @(negedge axis_clk);
    if (m_awvalid || m_wvalid || m_arvalid || m_rready || aa_as_tvalid || mb_irq ||
        !aa_as_tready) begin
      error_count++;
      $display("Error at %0d ns: outputs not in their reset state", $time);
    end
    axis_rst_n = 1'b1;
    @(negedge axis_clk);
    for (int i = 0; i < n_entries && !timed_out; i++) begin
      ent = cmd_table[i];
      // regions 2 and 3 stay inside the bridge
      is_local = (ent.addr[15:12] == aa_map_pkg::REGION_AA_REG) ||
                 (ent.addr[15:12] == aa_map_pkg::REGION_MBOX);
      case (ent.code)
        c_wr: begin
          if (!is_local) begin
            exp_wr.push_back({ent.addr & 32'h0FFF_FFFF, ent.addr[31:28], ent.data});
          end
          send_beat(c_wr, ent.addr);
          send_beat(c_wr, ent.data);
        end
        c_rd: begin
          if (!is_local) begin
            exp_ar.push_back(ent.addr & 32'h0FFF_FFFF);
          end
          exp_rsp.push_back(ent.exp);
          send_beat(c_rd, ent.addr);
        end
        default: send_beat(ent.code, ent.data);
      endcase
      if (ent.chk_irq) begin
        wait_drained("responses before irq check");
        if (mb_irq !== ent.irq) begin
          error_count++;
          $display("Error at %0d ns: entry %0d mb_irq %b expected %b", $time, i,
                   mb_irq, ent.irq);
        end
      end
      repeat ($urandom % 3) @(negedge axis_clk);
    end
    wait_drained("final responses");
    finish_run();
  end

endmodule

// File: flist.f
design/aa_types_pkg.sv
design/aa_map_pkg.sv
design/aa_cmd_if.sv
design/aa_reg_if.sv
design/aa_cmd_rx.sv
design/aa_exec.sv
design/aa_local_regs.sv
design/aa_resp_tx.sv
design/aa_bridge_top.sv
test/tb_aa_bridge.sv

// File: Makefile
TOP := tb_aa_bridge

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing -f flist.f --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -F -q "*** PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log
